// ==== verilog/ArmPkg.sv ====
package ArmPkg;

    localparam int RegCount = 16;

    typedef logic [31:0] wordT;
    typedef logic [3:0]  regIdxT;
    typedef logic [3:0]  flagsT;         // N, Z, C, V from the top bit down.
    typedef logic [11:0] shiftOperandT;
    typedef logic [1:0]  modeT;

    localparam modeT ModeData = 2'd0;
    localparam modeT ModeMem  = 2'd1;

    // Condition field without NV (4'hf).
    typedef enum logic [3:0] {
        CondEq, CondNe, CondCs, CondCc, CondMi, CondPl, CondVs, CondVc,
        CondHi, CondLs, CondGe, CondLt, CondGt, CondLe, CondAl
    } condT;

    typedef enum logic [3:0] {
        OpAnd = 4'b0000,
        OpEor = 4'b0001,
        OpSub = 4'b0010,
        OpAdd = 4'b0100,
        OpAdc = 4'b0101,
        OpSbc = 4'b0110,
        OpTst = 4'b1000,
        OpCmp = 4'b1010,
        OpOrr = 4'b1100,
        OpMov = 4'b1101,
        OpMvn = 4'b1111
    } opCodeT;

    // Execute commands as the ALU sees them.
    typedef enum logic [3:0] {
        CmdMov = 4'b0001,
        CmdMvn = 4'b1001,
        CmdAdd = 4'b0010,
        CmdAdc = 4'b0011,
        CmdSub = 4'b0100,
        CmdSbc = 4'b0101,
        CmdAnd = 4'b0110,
        CmdOrr = 4'b0111,
        CmdEor = 4'b1000
    } exeCmdT;

endpackage

// ==== verilog/PipePkg.sv ====
package PipePkg;

    // Fetch queue entries, and the credits a producer starts with.
    localparam int QueueDepth = 4;
    localparam int QueuePtrBits = $clog2(QueueDepth);

    typedef logic [QueuePtrBits-1:0] queuePtrT;
    typedef logic [QueuePtrBits:0]   queueCountT;   // Holds 0 up to QueueDepth.

    localparam int MemWords = 64;

    typedef logic [$clog2(MemWords)-1:0] MemIdxT;

endpackage

// ==== verilog/StageIf.sv ====
`timescale 1ns/1ps

// ID/EX register contents.
interface DecodeBus;
    import ArmPkg::*;

    exeCmdT       exeCmd;
    logic         setFlags;
    logic         memWrite;
    logic         memRead;
    logic         wbEnable;
    regIdxT       dest;
    wordT         valRn;
    wordT         valRm;
    logic         immFlag;
    shiftOperandT shiftOperand;

    modport source (output exeCmd, setFlags, memWrite, memRead, wbEnable, dest,
                    valRn, valRm, immFlag, shiftOperand);
    modport sink (input exeCmd, setFlags, memWrite, memRead, wbEnable, dest,
                  valRn, valRm, immFlag, shiftOperand);
    modport monitor (input dest, wbEnable, setFlags);
endinterface

// EX/MEM register contents.
interface ExecBus;
    import ArmPkg::*;

    wordT   aluResult;
    wordT   storeValue;
    regIdxT dest;
    logic   memRead;
    logic   memWrite;
    logic   wbEnable;

    modport source (output aluResult, storeValue, dest, memRead, memWrite, wbEnable);
    modport sink (input aluResult, storeValue, dest, memRead, memWrite, wbEnable);
    modport monitor (input dest, wbEnable);
endinterface

interface HazardBus;
    import ArmPkg::*;

    regIdxT src1;
    regIdxT src2;
    logic   twoSrc;
    logic   condUsed;
    logic   stall;

    modport id (output src1, src2, twoSrc, condUsed, input stall);
    modport unit (input src1, src2, twoSrc, condUsed, output stall);
endinterface

// ==== verilog/FetchQueue.sv ====
`timescale 1ns/1ps

module FetchQueue (
    input  logic         clk,
    input  logic         reset,
    input  logic         instrValid,
    input  ArmPkg::wordT instr,
    input  logic         pop,
    output logic         headValid,
    output ArmPkg::wordT headInstr,
    output logic         instrCredit
);
    import ArmPkg::*;
    import PipePkg::*;

    wordT       slots [QueueDepth];
    queuePtrT   writePtr;
    queuePtrT   readPtr;
    queueCountT count;

    assign headValid = (count != '0);
    assign headInstr = slots[readPtr];

    always_ff @(posedge clk) begin
        if (instrValid) begin
            slots[writePtr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) writePtr <= writePtr + 1'b1;   // Wraps with the power-of-two depth.
            if (pop) readPtr <= readPtr + 1'b1;
            if (instrValid && !pop) begin
                count <= count + 1'b1;
            end else if (!instrValid && pop) begin
                count <= count - 1'b1;
            end
            instrCredit <= pop;   // Freed slot goes back to the producer.
        end
    end

    // Credits must keep the producer from ever overrunning the queue.
    noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
        instrValid |-> count != queueCountT'(QueueDepth));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) pop |-> headValid);

endmodule

// ==== verilog/ControlUnit.sv ====
`timescale 1ns/1ps

module ControlUnit (
    input  ArmPkg::modeT   mode,
    input  ArmPkg::opCodeT opCode,
    input  logic           sBit,
    output ArmPkg::exeCmdT exeCmd,
    output logic           setFlags,
    output logic           memWrite,
    output logic           memRead,
    output logic           wbEnable
);
    import ArmPkg::*;

    always_comb begin
        exeCmd = CmdMov;
        setFlags = 1'b0;
        memWrite = 1'b0;
        memRead = 1'b0;
        wbEnable = 1'b0;
        if (mode == ModeData) begin
            setFlags = sBit;
            wbEnable = 1'b1;
            case (opCode)
                OpMov: exeCmd = CmdMov;
                OpMvn: exeCmd = CmdMvn;
                OpAdd: exeCmd = CmdAdd;
                OpAdc: exeCmd = CmdAdc;
                OpSub: exeCmd = CmdSub;
                OpSbc: exeCmd = CmdSbc;
                OpAnd: exeCmd = CmdAnd;
                OpOrr: exeCmd = CmdOrr;
                OpEor: exeCmd = CmdEor;
                OpCmp: begin
                    exeCmd = CmdSub;   // Flags only.
                    wbEnable = 1'b0;
                end
                OpTst: begin
                    exeCmd = CmdAnd;
                    wbEnable = 1'b0;
                end
                default: begin
                    setFlags = 1'b0;
                    wbEnable = 1'b0;
                end
            endcase
        end else if (mode == ModeMem) begin
            // Address is base plus offset; bit 20 picks load over store.
            exeCmd = CmdAdd;
            memRead = sBit;
            wbEnable = sBit;
            memWrite = ~sBit;
        end
    end

endmodule

// ==== verilog/RegisterFile.sv ====
`timescale 1ns/1ps

module RegisterFile (
    input  logic           clk,
    input  logic           reset,
    input  logic           writeEnable,
    input  ArmPkg::regIdxT writeReg,
    input  ArmPkg::wordT   writeData,
    input  ArmPkg::regIdxT readReg1,
    input  ArmPkg::regIdxT readReg2,
    output ArmPkg::wordT   readData1,
    output ArmPkg::wordT   readData2
);
    import ArmPkg::*;

    wordT regs [RegCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeReg] <= writeData;
        end
    end

    // Bypass so decode sees a value written back in the same cycle.
    assign readData1 = (writeEnable && writeReg == readReg1) ? writeData : regs[readReg1];
    assign readData2 = (writeEnable && writeReg == readReg2) ? writeData : regs[readReg2];

endmodule

// ==== verilog/IdStage.sv ====
`timescale 1ns/1ps

module IdStage (
    input  logic           clk,
    input  logic           reset,
    input  logic           headValid,
    input  ArmPkg::wordT   headInstr,
    output logic           pop,
    input  ArmPkg::flagsT  flags,
    input  logic           wbEnable,
    input  ArmPkg::regIdxT wbDest,
    input  ArmPkg::wordT   wbValue,
    HazardBus.id           hazard,
    DecodeBus.source       decode
);
    import ArmPkg::*;

    condT   cond;
    modeT   mode;
    opCodeT opCode;
    logic   sBit;
    logic   immFlag;
    regIdxT rn;
    regIdxT rd;
    regIdxT rm;
    regIdxT readReg2;
    wordT   valRn;
    wordT   valRm;
    exeCmdT ctrlExeCmd;
    logic   ctrlSetFlags;
    logic   ctrlMemWrite;
    logic   ctrlMemRead;
    logic   ctrlWbEnable;
    logic   condPass;
    logic   bubble;
    logic   n, z, c, v;

    assign cond = condT'(headInstr[31:28]);
    assign mode = headInstr[27:26];
    assign immFlag = headInstr[25];
    assign opCode = opCodeT'(headInstr[24:21]);
    assign sBit = headInstr[20];
    assign rn = headInstr[19:16];
    assign rd = headInstr[15:12];
    assign rm = headInstr[3:0];
    assign {n, z, c, v} = flags;

    ControlUnit controlUnit (
        .mode(mode), .opCode(opCode), .sBit(sBit),
        .exeCmd(ctrlExeCmd), .setFlags(ctrlSetFlags), .memWrite(ctrlMemWrite),
        .memRead(ctrlMemRead), .wbEnable(ctrlWbEnable)
    );

    assign readReg2 = ctrlMemWrite ? rd : rm;   // STR reads the register it stores.

    RegisterFile registerFile (
        .clk(clk), .reset(reset),
        .writeEnable(wbEnable), .writeReg(wbDest), .writeData(wbValue),
        .readReg1(rn), .readReg2(readReg2),
        .readData1(valRn), .readData2(valRm)
    );

    always_comb begin
        case (cond)
            CondEq: condPass = z;
            CondNe: condPass = ~z;
            CondCs: condPass = c;
            CondCc: condPass = ~c;
            CondMi: condPass = n;
            CondPl: condPass = ~n;
            CondVs: condPass = v;
            CondVc: condPass = ~v;
            CondHi: condPass = c & ~z;
            CondLs: condPass = ~c | z;
            CondGe: condPass = (n == v);
            CondLt: condPass = (n != v);
            CondGt: condPass = ~z & (n == v);
            CondLe: condPass = z | (n != v);
            CondAl: condPass = 1'b1;
            default: condPass = 1'b0;   // NV never runs.
        endcase
    end

    assign hazard.src1 = rn;
    assign hazard.src2 = readReg2;
    assign hazard.twoSrc = ~immFlag | ctrlMemWrite;
    assign hazard.condUsed = (cond != CondAl);

    assign pop = headValid & ~hazard.stall;
    assign bubble = hazard.stall | ~headValid | ~condPass;

    always_ff @(posedge clk) begin
        if (reset) begin
            decode.setFlags <= 1'b0;
            decode.memWrite <= 1'b0;
            decode.memRead <= 1'b0;
            decode.wbEnable <= 1'b0;
        end else begin
            decode.setFlags <= ctrlSetFlags & ~bubble;
            decode.memWrite <= ctrlMemWrite & ~bubble;
            decode.memRead <= ctrlMemRead & ~bubble;
            decode.wbEnable <= ctrlWbEnable & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        decode.exeCmd <= ctrlExeCmd;
        decode.dest <= rd;
        decode.valRn <= valRn;
        decode.valRm <= valRm;
        decode.immFlag <= immFlag;
        decode.shiftOperand <= headInstr[11:0];
    end

endmodule

// ==== verilog/ExeStage.sv ====
`timescale 1ns/1ps

module ExeStage (
    input  logic          clk,
    input  logic          reset,
    DecodeBus.sink        decode,
    ExecBus.source        exec,
    output ArmPkg::flagsT flags
);
    import ArmPkg::*;

    wordT        operand2;
    wordT        imm8;
    logic [63:0] immPair;
    logic [63:0] rorPair;
    logic [4:0]  shiftAmount;
    wordT        addB;
    logic        addCin;
    logic [32:0] sum;
    wordT        result;
    logic        arith;
    logic        overflow;
    flagsT       newFlags;

    assign imm8 = {24'b0, decode.shiftOperand[7:0]};
    assign immPair = {imm8, imm8} >> {decode.shiftOperand[11:8], 1'b0};
    assign shiftAmount = decode.shiftOperand[11:7];
    assign rorPair = {decode.valRm, decode.valRm} >> shiftAmount;

    always_comb begin
        if (decode.memRead || decode.memWrite) begin
            operand2 = {20'b0, decode.shiftOperand};   // Unsigned load/store offset.
        end else if (decode.immFlag) begin
            operand2 = immPair[31:0];
        end else begin
            case (decode.shiftOperand[6:5])
                2'b00: operand2 = decode.valRm << shiftAmount;
                2'b01: operand2 = decode.valRm >> shiftAmount;
                2'b10: operand2 = $signed(decode.valRm) >>> shiftAmount;
                default: operand2 = rorPair[31:0];
            endcase
        end
    end

    // Subtraction adds the inverted operand; carry means no borrow.
    always_comb begin
        addB = operand2;
        addCin = 1'b0;
        case (decode.exeCmd)
            CmdAdc: addCin = flags[1];
            CmdSub: begin
                addB = ~operand2;
                addCin = 1'b1;
            end
            CmdSbc: begin
                addB = ~operand2;
                addCin = flags[1];
            end
            default: addCin = 1'b0;
        endcase
    end

    assign sum = {1'b0, decode.valRn} + {1'b0, addB} + {32'b0, addCin};
    assign overflow = (decode.valRn[31] == addB[31]) && (sum[31] != decode.valRn[31]);

    always_comb begin
        arith = 1'b0;
        case (decode.exeCmd)
            CmdMov: result = operand2;
            CmdMvn: result = ~operand2;
            CmdAnd: result = decode.valRn & operand2;
            CmdOrr: result = decode.valRn | operand2;
            CmdEor: result = decode.valRn ^ operand2;
            default: begin
                result = sum[31:0];
                arith = 1'b1;
            end
        endcase
    end

    // Logic ops leave C and V as they were.
    assign newFlags = {result[31], result == '0, arith ? sum[32] : flags[1],
                       arith ? overflow : flags[0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            exec.memRead <= 1'b0;
            exec.memWrite <= 1'b0;
            exec.wbEnable <= 1'b0;
            flags <= '0;
        end else begin
            exec.memRead <= decode.memRead;
            exec.memWrite <= decode.memWrite;
            exec.wbEnable <= decode.wbEnable;
            if (decode.setFlags) flags <= newFlags;
        end
    end

    always_ff @(posedge clk) begin
        exec.aluResult <= result;
        exec.storeValue <= decode.valRm;
        exec.dest <= decode.dest;
    end

    // Decode never marks one instruction as both load and store.
    oneMemOp: assert property (@(posedge clk) disable iff (reset)
        !(decode.memRead && decode.memWrite));

endmodule

// ==== verilog/MemStage.sv ====
`timescale 1ns/1ps

module MemStage (
    input  logic           clk,
    input  logic           reset,
    ExecBus.sink           exec,
    output logic           wbEnable,
    output ArmPkg::regIdxT wbDest,
    output ArmPkg::wordT   wbValue
);
    import ArmPkg::*;
    import PipePkg::*;

    wordT   dataMem [MemWords];
    MemIdxT memIdx;

    assign memIdx = exec.aluResult[$bits(MemIdxT)+1:2];   // Word address.

    always_ff @(posedge clk) begin
        if (exec.memWrite) begin
            dataMem[memIdx] <= exec.storeValue;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbEnable <= 1'b0;
        end else begin
            wbEnable <= exec.wbEnable;
        end
    end

    always_ff @(posedge clk) begin
        wbDest <= exec.dest;
        wbValue <= exec.memRead ? dataMem[memIdx] : exec.aluResult;
    end

    wordAligned: assert property (@(posedge clk) disable iff (reset)
        (exec.memRead || exec.memWrite) |-> exec.aluResult[1:0] == 2'b00);

endmodule

// ==== verilog/HazardUnit.sv ====
`timescale 1ns/1ps

module HazardUnit (
    HazardBus.unit    hazard,
    DecodeBus.monitor decode,
    ExecBus.monitor   exec
);
    logic src1Hit;
    logic src2Hit;
    logic flagHit;

    // Rn is compared even when the instruction has no Rn.
    assign src1Hit = (decode.wbEnable && hazard.src1 == decode.dest) ||
                     (exec.wbEnable && hazard.src1 == exec.dest);
    assign src2Hit = hazard.twoSrc &&
                     ((decode.wbEnable && hazard.src2 == decode.dest) ||
                      (exec.wbEnable && hazard.src2 == exec.dest));
    assign flagHit = hazard.condUsed && decode.setFlags;   // Flags not yet written.

    assign hazard.stall = src1Hit | src2Hit | flagHit;

endmodule

// ==== verilog/ArmPipeline.sv ====
`timescale 1ns/1ps

module ArmPipeline (
    input  logic           clk,
    input  logic           reset,
    input  logic           instrValid,
    input  ArmPkg::wordT   instr,
    output logic           instrCredit,
    output logic           wbValid,
    output ArmPkg::regIdxT wbDest,
    output ArmPkg::wordT   wbValue
);
    import ArmPkg::*;

    logic  headValid;
    wordT  headInstr;
    logic  pop;
    flagsT flags;

    DecodeBus decodeBus ();
    ExecBus   execBus ();
    HazardBus hazardBus ();

    FetchQueue fetchQueue (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .pop(pop),
        .headValid(headValid), .headInstr(headInstr), .instrCredit(instrCredit)
    );

    IdStage idStage (
        .clk(clk), .reset(reset), .headValid(headValid), .headInstr(headInstr),
        .pop(pop), .flags(flags), .wbEnable(wbValid), .wbDest(wbDest),
        .wbValue(wbValue), .hazard(hazardBus.id), .decode(decodeBus.source)
    );

    ExeStage exeStage (
        .clk(clk), .reset(reset), .decode(decodeBus.sink), .exec(execBus.source),
        .flags(flags)
    );

    MemStage memStage (
        .clk(clk), .reset(reset), .exec(execBus.sink),
        .wbEnable(wbValid), .wbDest(wbDest), .wbValue(wbValue)
    );

    HazardUnit hazardUnit (
        .hazard(hazardBus.unit), .decode(decodeBus.monitor), .exec(execBus.monitor)
    );

endmodule

// ==== bench/ArmPipelineTb.sv ====
`timescale 1ns/1ps

module ArmPipelineTb;
    import ArmPkg::*;
    import PipePkg::*;

    localparam int NumInstr = 400;
    localparam int WaitLimit = 200;

    logic   clk;
    logic   reset;
    logic   instrValid;
    wordT   instr;
    logic   instrCredit;
    logic   wbValid;
    regIdxT wbDest;
    wordT   wbValue;

    // Reference model state.
    wordT   refRegs [RegCount] = '{default: '0};
    flagsT  refFlags = '0;
    wordT   refMem [MemWords];
    regIdxT expDests [$];
    wordT   expValues [$];
    int     storedIdx [$];   // Word slots some store has written.

    int          credits = QueueDepth;
    logic [31:0] rngState = 32'd26;
    opCodeT      opList [11] = '{OpMov, OpMvn, OpAdd, OpAdc, OpSub, OpSbc,
                                 OpAnd, OpOrr, OpEor, OpCmp, OpTst};

    ArmPipeline u_ArmPipeline (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
        .instrCredit(instrCredit), .wbValid(wbValid), .wbDest(wbDest), .wbValue(wbValue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic wordT rotateRight(input wordT x, input int r);
        if (r == 0) return x;
        return (x >> r) | (x << (32 - r));
    endfunction

    function automatic void recordWrite(input regIdxT rd, input wordT value);
        refRegs[rd] = value;
        expDests.push_back(rd);
        expValues.push_back(value);
    endfunction

    // Executes one instruction on the model in program order.
    function automatic void refExecute(input wordT ins);
        logic [3:0]  opc;
        regIdxT      rn;
        regIdxT      rd;
        logic        n, z, c, v;
        logic        pass;
        logic        arith;
        logic        isSub;
        wordT        a;
        wordT        op2;
        wordT        res;
        wordT        addr;
        logic [32:0] wide;
        logic [4:0]  amt;
        opc = ins[24:21];
        rn = ins[19:16];
        rd = ins[15:12];
        amt = ins[11:7];
        {n, z, c, v} = refFlags;
        case (ins[31:28])
            4'h0: pass = z;
            4'h1: pass = !z;
            4'h2: pass = c;
            4'h3: pass = !c;
            4'h4: pass = n;
            4'h5: pass = !n;
            4'h6: pass = v;
            4'h7: pass = !v;
            4'h8: pass = c && !z;
            4'h9: pass = !c || z;
            4'ha: pass = (n == v);
            4'hb: pass = (n != v);
            4'hc: pass = !z && (n == v);
            4'hd: pass = z || (n != v);
            4'he: pass = 1'b1;
            default: pass = 1'b0;
        endcase
        if (!pass) return;
        a = refRegs[rn];
        if (ins[27:26] == ModeMem) begin
            addr = a + {20'b0, ins[11:0]};
            if (ins[20]) recordWrite(rd, refMem[addr[7:2]]);
            else refMem[addr[7:2]] = refRegs[rd];
            return;
        end
        if (ins[25]) begin
            op2 = rotateRight({24'b0, ins[7:0]}, 2 * ins[11:8]);
        end else begin
            case (ins[6:5])
                2'b00: op2 = refRegs[ins[3:0]] << amt;
                2'b01: op2 = refRegs[ins[3:0]] >> amt;
                2'b10: op2 = $signed(refRegs[ins[3:0]]) >>> amt;
                default: op2 = rotateRight(refRegs[ins[3:0]], amt);
            endcase
        end
        arith = 1'b1;
        wide = '0;
        isSub = (opc == OpSub || opc == OpCmp || opc == OpSbc);
        case (opc)
            OpAdd: wide = {1'b0, a} + {1'b0, op2};
            OpAdc: wide = {1'b0, a} + {1'b0, op2} + c;
            OpSub, OpCmp: wide = {1'b0, a} - {1'b0, op2};
            OpSbc: wide = {1'b0, a} - {1'b0, op2} - !c;   // Borrow is the inverted carry.
            default: arith = 1'b0;
        endcase
        case (opc)
            OpMov: res = op2;
            OpMvn: res = ~op2;
            OpAnd, OpTst: res = a & op2;
            OpOrr: res = a | op2;
            OpEor: res = a ^ op2;
            default: res = wide[31:0];
        endcase
        if (ins[20]) begin
            n = res[31];
            z = (res == '0);
            if (arith) begin
                c = isSub ? !wide[32] : wide[32];
                v = isSub ? (a[31] != op2[31] && res[31] != a[31])
                          : (a[31] == op2[31] && res[31] != a[31]);
            end
            refFlags = {n, z, c, v};
        end
        if (opc != OpCmp && opc != OpTst) recordWrite(rd, res);
    endfunction

    // One in four is a load or store with base R12 (0x40) or R13 (zero).
    task automatic makeInstr(output wordT ins);
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        int          idx;
        logic        load;
        regIdxT      base;
        regIdxT      rn;
        regIdxT      rd;
        logic [3:0]  cond;
        logic [11:0] operand;
        opCodeT      opc;
        logic        sBit;
        r = nextRand();
        r2 = nextRand();
        r3 = nextRand();
        if (r[1:0] == 2'b00) begin
            load = r[2] && storedIdx.size() != 0;
            if (load) begin
                idx = storedIdx[r2 % storedIdx.size()];
                rd = regIdxT'(r3[15:8] % 12);
            end else begin
                idx = int'(r2 % MemWords);
                rd = regIdxT'(r3[15:8] % 14);
                storedIdx.push_back(idx);
            end
            base = (idx >= 16 && r[3]) ? 4'd12 : 4'd13;
            operand = (base == 4'd12) ? 12'(idx * 4 - 'h40) : 12'(idx * 4);
            ins = {4'he, ModeMem, 1'b0, 4'b1100, load, base, rd, operand};
        end else begin
            opc = opList[r2 % 11];
            cond = (r[4:3] == 2'b00) ? 4'(r[31:8] % 15) : 4'he;
            sBit = r[5] || opc == OpCmp || opc == OpTst;
            rn = regIdxT'(r3[7:0] % 14);
            rd = regIdxT'(r3[15:8] % 12);   // R12 and R13 stay as bases.
            if (r[6]) operand = r3[27:16];
            else operand = {r2[31:27], r2[26:25], 1'b0, 4'(r3[31:28] % 14)};
            ins = {cond, ModeData, r[6], opc, sBit, rn, rd, operand};
        end
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failed check.");
    endtask

    task automatic sendInstr(input wordT ins);
        int waitCycles;
        waitCycles = 0;
        while (credits == 0 || nextRand() % 4 == 0) begin   // Idle, or no credit.
            instrValid = 1'b0;
            @(posedge clk);
            #1;
            waitCycles++;
            if (waitCycles > WaitLimit) reportFailure("Timeout: no instruction credit came back.");
        end
        instrValid = 1'b1;
        instr = ins;
        credits--;
        refExecute(ins);
        @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        wordT ins;
        int   waitCycles;
        $timeformat(-9, 0, " ns", 0);
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NumInstr; i++) begin
            if (i == 0) begin
                ins = {4'he, ModeData, 1'b0, OpAdd, 1'b0, 4'd1, 4'd0, 12'h002};   // R0 = R1 + R2.
            end else if (i == 1) begin
                ins = {4'he, ModeData, 1'b1, OpMov, 1'b0, 4'd0, 4'd12, 12'h040};
            end else begin
                makeInstr(ins);
            end
            sendInstr(ins);
        end
        instrValid = 1'b0;
        waitCycles = 0;
        while (expDests.size() != 0 || credits != QueueDepth) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > WaitLimit) reportFailure("Timeout: pipeline did not drain.");
        end
        repeat (5) @(posedge clk);   // Room for a stray writeback.
        $display("Finished with no errors");
        $finish;
    end

    initial begin : compare
        regIdxT expDest;
        wordT   expValue;
        forever begin
            @(negedge clk);
            if (reset) begin
                assert (!wbValid && !instrCredit)
                    else reportFailure("wbValid or instrCredit was high during reset.");
            end else begin
                if (instrCredit) begin
                    credits++;
                    assert (credits <= QueueDepth)
                        else reportFailure("More credits came back than were spent.");
                end
                if (wbValid) begin
                    assert (expDests.size() != 0)
                        else reportFailure("Writeback seen with no writing instruction pending.");
                    expDest = expDests.pop_front();
                    expValue = expValues.pop_front();
                    assert (wbDest == expDest) else reportFailure($sformatf(
                        "ERROR at %0t: wbDest expected %0d, got %0d", $time, expDest, wbDest));
                    assert (wbValue == expValue) else reportFailure($sformatf(
                        "ERROR at %0t: wbValue expected 0x%08h, got 0x%08h",
                        $time, expValue, wbValue));
                end
            end
        end
    end

endmodule

// ==== build.f ====
verilog/ArmPkg.sv
verilog/PipePkg.sv
verilog/StageIf.sv
verilog/FetchQueue.sv
verilog/ControlUnit.sv
verilog/RegisterFile.sv
verilog/IdStage.sv
verilog/ExeStage.sv
verilog/MemStage.sv
verilog/HazardUnit.sv
verilog/ArmPipeline.sv
bench/ArmPipelineTb.sv

// ==== Bender.yml ====
package:
  name: arm_pipeline

sources:
  - files:
      - verilog/ArmPkg.sv
      - verilog/PipePkg.sv
      - verilog/StageIf.sv
      - verilog/FetchQueue.sv
      - verilog/ControlUnit.sv
      - verilog/RegisterFile.sv
      - verilog/IdStage.sv
      - verilog/ExeStage.sv
      - verilog/MemStage.sv
      - verilog/HazardUnit.sv
      - verilog/ArmPipeline.sv
  - target: test
    files:
      - bench/ArmPipelineTb.sv
